// ==== rtl/ucode_cfg.svh ====
`ifndef UCODE_CFG_SVH
`define UCODE_CFG_SVH

// ****************************************
// Instruction fields
// ****************************************

`define UC_OPCODE_W 16

// ****************************************
// Microcode ROM geometry
// ****************************************

`define UC_ENTRY_W  4
`define UC_STEP_W   2   // 4 lines per entry
`define UC_LINES    64

`endif

// ==== rtl/ucode_pkg.sv ====
`include "ucode_cfg.svh"

package ucode_pkg;

  // Instruction as seen by the decode
  typedef struct packed {
    logic [`UC_OPCODE_W-1:0] opcode;
    logic [2:0]              modrm_reg;  // ModR/M bits 5:3
    logic                    sizeop;
  } instr_t;

  typedef struct packed {
    logic [`UC_ENTRY_W-1:0] entry;
    logic                   use_rom;
  } rom_sel_t;

  // ****************************************
  // Micro-op kinds
  // ****************************************
  typedef enum logic [3:0] {
    PASS      = 4'd0,
    PUSH_IP   = 4'd1,
    PUSH_CS   = 4'd2,
    POP_IP    = 4'd3,
    POP_CS    = 4'd4,
    POP_FLAGS = 4'd5,
    ADJ_SP    = 4'd6,
    LOAD_TGT  = 4'd7,
    LOAD_CS   = 4'd8,
    JMP_REL   = 4'd9,
    JMP_ABS   = 4'd10,
    FAULT     = 4'd11
  } uop_kind_e;

  typedef struct packed {
    uop_kind_e kind;
    logic      last;   // End of sequence
  } rom_line_t;

  typedef struct packed {
    uop_kind_e               kind;
    logic                    sizeop;
    logic [`UC_OPCODE_W-1:0] opcode;
    logic [`UC_STEP_W-1:0]   step;
    logic                    last;
  } uop_t;

endpackage

// ==== rtl/opcode_rom_control.sv ====
`include "ucode_cfg.svh"

module opcode_rom_control
  import ucode_pkg::*;
(
  input  instr_t   instr,
  output rom_sel_t sel
);

  logic [`UC_OPCODE_W-1:0] op;
  logic                    sz_n;
  logic                    ff_call;  // FF /2, any low byte
  logic [14:0]             pt;

  always_comb begin
    op      = instr.opcode;
    sz_n    = ~instr.sizeop;
    ff_call = (instr.modrm_reg == 3'b010) && (op[15:8] == 8'hFF);

    // ****************************************
    // Product terms
    // ****************************************
    pt[0]  = (op == 16'hE800);
    pt[1]  = ff_call;
    pt[2]  = sz_n && (op ==? 16'b1100_?010_0000_0000);  // C2, CA
    pt[3]  = sz_n && (op == 16'h9A00);
    pt[4]  = sz_n && (op == 16'hCF00);
    pt[5]  = ff_call;
    pt[6]  = sz_n && ff_call;
    pt[7]  = sz_n && (op == 16'hE800);
    pt[8]  = sz_n && (op == 16'h9A00);
    pt[9]  = sz_n && (op ==? 16'b1100_?01?_0000_0000);  // C2, C3, CA, CB
    pt[10] = sz_n && (op == 16'h9A00);
    pt[11] = (op == 16'hE800);
    pt[12] = sz_n && (op == 16'hCF00);
    pt[13] = ff_call;
    pt[14] = sz_n && (op ==? 16'b1100_?010_0000_0000);

    // ****************************************
    // OR groups
    // ****************************************
    sel.entry[3] = pt[0] | pt[1];
    sel.entry[2] = pt[2];
    sel.entry[1] = pt[3] | pt[4] | pt[5];
    sel.entry[0] = pt[6] | pt[7] | pt[8] | pt[9];
    sel.use_rom  = pt[10] | pt[11] | pt[12] | pt[13] | pt[14];

    // Entry 0 is never a ROM sequence
    assert (!sel.use_rom || sel.entry != '0)
      else $error("use_rom set with entry 0, opcode %h", op);
  end

endmodule

// ==== rtl/ucode_rom.sv ====
`include "ucode_cfg.svh"

module ucode_rom
  import ucode_pkg::*;
(
  input  logic [`UC_ENTRY_W-1:0] entry,
  input  logic [`UC_STEP_W-1:0]  step,
  output rom_line_t              line
);

  localparam int ADDR_W = $clog2(`UC_LINES);

  logic [ADDR_W-1:0] addr;

  function automatic rom_line_t mk(input uop_kind_e kind, input logic last);
    rom_line_t l;
    l.kind = kind;
    l.last = last;
    return l;
  endfunction

  assign addr = {entry, step};

  always_comb begin
    line = mk(FAULT, 1'b1);  // Unused entries and steps past the end
    case (addr)
      // ****************************************
      // Interrupt return
      // ****************************************
      {4'd2, 2'd0}: line = mk(POP_IP, 1'b0);
      {4'd2, 2'd1}: line = mk(POP_CS, 1'b0);
      {4'd2, 2'd2}: line = mk(POP_FLAGS, 1'b1);

      // ****************************************
      // Far call
      // ****************************************
      {4'd3, 2'd0}: line = mk(PUSH_CS, 1'b0);
      {4'd3, 2'd1}: line = mk(PUSH_IP, 1'b0);
      {4'd3, 2'd2}: line = mk(LOAD_CS, 1'b0);
      {4'd3, 2'd3}: line = mk(JMP_ABS, 1'b1);

      // Return with immediate
      {4'd5, 2'd0}: line = mk(POP_IP, 1'b0);
      {4'd5, 2'd1}: line = mk(ADJ_SP, 1'b1);

      // Near call rel, both sizes
      {4'd8, 2'd0},
      {4'd9, 2'd0}: line = mk(PUSH_IP, 1'b0);
      {4'd8, 2'd1},
      {4'd9, 2'd1}: line = mk(JMP_REL, 1'b1);

      // Call indirect, both sizes
      {4'd10, 2'd0},
      {4'd11, 2'd0}: line = mk(LOAD_TGT, 1'b0);
      {4'd10, 2'd1},
      {4'd11, 2'd1}: line = mk(PUSH_IP, 1'b0);
      {4'd10, 2'd2},
      {4'd11, 2'd2}: line = mk(JMP_ABS, 1'b1);

      default: ;
    endcase
  end

endmodule

// ==== rtl/ucode_sequencer.sv ====
`include "ucode_cfg.svh"

module ucode_sequencer
  import ucode_pkg::*;
(
  input  logic                   clk,
  input  logic                   arst_n,
  input  logic                   instr_valid,
  input  instr_t                 instr,
  input  rom_sel_t               sel,
  input  rom_line_t              line,
  output logic [`UC_ENTRY_W-1:0] entry,
  output logic [`UC_STEP_W-1:0]  step,
  output logic                   busy,
  output logic                   uop_valid,
  output uop_t                   uop
);

  instr_t                instr_q;
  rom_sel_t              sel_q;
  logic [`UC_STEP_W-1:0] step_q;
  logic                  cur_last;
  uop_t                  uop_nxt;

  assign entry = sel_q.entry;
  assign step  = step_q;

  // ****************************************
  // Instruction latch and step counter
  // ****************************************
  always_ff @(posedge clk) begin
    if (instr_valid) begin
      instr_q <= instr;
      sel_q   <= sel;    // Decoded from the same instr
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      busy   <= 1'b0;
      step_q <= '0;
    end else if (instr_valid) begin
      busy   <= 1'b1;
      step_q <= '0;
    end else if (busy) begin
      if (cur_last) busy <= 1'b0;
      else step_q <= step_q + 1'b1;
    end
  end

  // ****************************************
  // Micro-op output
  // ****************************************
  assign cur_last = sel_q.use_rom ? line.last : 1'b1;  // Single PASS otherwise

  always_comb begin
    uop_nxt.kind   = sel_q.use_rom ? line.kind : PASS;
    uop_nxt.sizeop = instr_q.sizeop;
    uop_nxt.opcode = instr_q.opcode;
    uop_nxt.step   = step_q;
    uop_nxt.last   = cur_last;
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) uop_valid <= 1'b0;
    else uop_valid <= busy;
  end

  always_ff @(posedge clk) begin
    if (busy) uop <= uop_nxt;
  end

  // ****************************************
  // Checks
  // ****************************************
  a_no_issue_while_busy: assert property (
    @(posedge clk) disable iff (!arst_n)
    instr_valid |-> !busy)
    else $error("instr_valid while busy");

  // A sequence must end before the counter runs out
  a_step_no_wrap: assert property (
    @(posedge clk) disable iff (!arst_n)
    busy && !cur_last |-> step_q != '1)
    else $error("step counter wrap, entry %0d", sel_q.entry);

endmodule

// ==== rtl/ucode_decode_top.sv ====
`include "ucode_cfg.svh"

module ucode_decode_top
  import ucode_pkg::*;
(
  input  logic   clk,
  input  logic   arst_n,
  input  logic   instr_valid,
  input  instr_t instr,
  output logic   busy,
  output logic   uop_valid,
  output uop_t   uop
);

  rom_sel_t               sel;
  rom_line_t              line;
  logic [`UC_ENTRY_W-1:0] entry;
  logic [`UC_STEP_W-1:0]  step;

  // Decode runs on the live instruction
  opcode_rom_control u_decode (
    .instr (instr),
    .sel   (sel)
  );

  ucode_rom u_rom (
    .entry (entry),
    .step  (step),
    .line  (line)
  );

  ucode_sequencer u_seq (
    .clk         (clk),
    .arst_n      (arst_n),
    .instr_valid (instr_valid),
    .instr       (instr),
    .sel         (sel),
    .line        (line),
    .entry       (entry),
    .step        (step),
    .busy        (busy),
    .uop_valid   (uop_valid),
    .uop         (uop)
  );

endmodule

// ==== test/ucode_decode_tb.sv ====
`include "ucode_cfg.svh"

module ucode_decode_tb
  import ucode_pkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int MAX_WAIT = 12;  // cycles per wait loop
  localparam int NUM_VECS = 13;
  localparam int NUM_RAND = 10;

  typedef struct packed {
    instr_t   ins;
    rom_sel_t sel;
  } vec_t;

  // opcode, ModR/M reg, sizeop, then expected entry, use_rom
  localparam vec_t VECS [NUM_VECS] = '{
    '{'{16'hE800, 3'd0, 1'b0}, '{4'd9,  1'b1}},
    '{'{16'hE800, 3'd0, 1'b1}, '{4'd8,  1'b1}},
    '{'{16'hFF10, 3'd2, 1'b0}, '{4'd11, 1'b1}},
    '{'{16'hFF00, 3'd2, 1'b1}, '{4'd10, 1'b1}},
    '{'{16'hC200, 3'd0, 1'b0}, '{4'd5,  1'b1}},
    '{'{16'hCA00, 3'd7, 1'b0}, '{4'd5,  1'b1}},
    '{'{16'hC300, 3'd0, 1'b0}, '{4'd1,  1'b0}},
    '{'{16'hCB00, 3'd0, 1'b0}, '{4'd1,  1'b0}},
    '{'{16'h9A00, 3'd0, 1'b0}, '{4'd3,  1'b1}},
    '{'{16'hCF00, 3'd0, 1'b0}, '{4'd2,  1'b1}},
    '{'{16'hC300, 3'd0, 1'b1}, '{4'd0,  1'b0}},
    '{'{16'hFF00, 3'd3, 1'b0}, '{4'd0,  1'b0}},
    '{'{16'hE801, 3'd0, 1'b0}, '{4'd0,  1'b0}}
  };

  logic        clk;
  logic        arst_n;
  logic        instr_valid;
  instr_t      instr;
  logic        busy;
  logic        uop_valid;
  uop_t        uop;
  logic [15:0] lfsr_state;
  int          errors;
  int          tests;

  ucode_decode_top uut (
    .clk         (clk),
    .arst_n      (arst_n),
    .instr_valid (instr_valid),
    .instr       (instr),
    .busy        (busy),
    .uop_valid   (uop_valid),
    .uop         (uop)
  );

  always #2 clk = ~clk;

  // ****************************************
  // Reference model
  // ****************************************
  function automatic rom_sel_t decode_ref(input instr_t i);
    rom_sel_t s;
    logic     low0;
    s = '0;
    low0 = (i.opcode[7:0] == 8'h00);
    if (i.opcode[15:8] == 8'hFF && i.modrm_reg == 3'b010) begin
      s.entry   = i.sizeop ? 4'd10 : 4'd11;
      s.use_rom = 1'b1;
    end else if (low0 && i.opcode[15:8] == 8'hE8) begin
      s.entry   = i.sizeop ? 4'd8 : 4'd9;
      s.use_rom = 1'b1;
    end else if (low0 && !i.sizeop) begin
      case (i.opcode[15:8])
        8'hC2, 8'hCA: s = '{4'd5, 1'b1};
        8'hC3, 8'hCB: s = '{4'd1, 1'b0};  // Plain return, no ROM
        8'h9A:        s = '{4'd3, 1'b1};
        8'hCF:        s = '{4'd2, 1'b1};
        default: ;
      endcase
    end
    return s;
  endfunction

  function automatic int ref_len(input rom_sel_t s);
    if (!s.use_rom) return 1;
    case (s.entry)
      4'd2, 4'd10, 4'd11: return 3;
      4'd3:               return 4;
      4'd5, 4'd8, 4'd9:   return 2;
      default:            return 1;
    endcase
  endfunction

  function automatic uop_kind_e ref_kind(input rom_sel_t s, input int idx);
    uop_kind_e k [4];
    k = '{FAULT, FAULT, FAULT, FAULT};
    if (!s.use_rom) return PASS;
    case (s.entry)
      4'd2:         k = '{POP_IP, POP_CS, POP_FLAGS, FAULT};
      4'd3:         k = '{PUSH_CS, PUSH_IP, LOAD_CS, JMP_ABS};
      4'd5:         k = '{POP_IP, ADJ_SP, FAULT, FAULT};
      4'd8, 4'd9:   k = '{PUSH_IP, JMP_REL, FAULT, FAULT};
      4'd10, 4'd11: k = '{LOAD_TGT, PUSH_IP, JMP_ABS, FAULT};
      default: ;
    endcase
    return k[idx[1:0]];
  endfunction

  function automatic logic next_rand_bit();
    logic out;
    out = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (out) lfsr_state = lfsr_state ^ 16'hB400;
    return out;
  endfunction

  function automatic logic [15:0] rand_bits(input int n);
    logic [15:0] v;
    int          i;
    v = '0;
    for (i = 0; i < n; i++) v = {v[14:0], next_rand_bit()};
    return v;
  endfunction

  // ****************************************
  // Compare tasks
  // ****************************************
  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      errors++;
      $display("FAILED %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_uop(input uop_t got, input uop_t exp);
    if (got !== exp) begin
      errors++;
      $display("FAILED uop got %h expected %h", got, exp);
    end
  endtask

  task automatic check_sel(input rom_sel_t got, input rom_sel_t exp);
    if (got !== exp) begin
      errors++;
      $display("FAILED uut.sel got %h expected %h", got, exp);
    end
  endtask

  // ****************************************
  // Stimulus and collection
  // ****************************************
  task automatic wait_idle();
    int n;
    n = 0;
    while (busy !== 1'b0 && n < MAX_WAIT) begin
      @(negedge clk);
      n++;
    end
    if (busy !== 1'b0) begin
      errors++;
      $display("busy stayed high for %0d cycles", MAX_WAIT);
    end
  endtask

  // Ends at the negedge of the cycle in which instr_valid is high
  task automatic issue(input instr_t ins);
    wait_idle();
    @(posedge clk);
    instr_valid <= 1'b1;
    instr       <= ins;
    @(negedge clk);
  endtask

  // With chain set, nxt is issued in the first cycle busy is low
  task automatic collect(input instr_t ins, input rom_sel_t exp_sel,
                         input bit chain, input instr_t nxt);
    int   n_exp;
    int   got;
    int   cyc;
    bit   done;
    uop_t exp;
    n_exp = ref_len(exp_sel);
    got = 0;
    done = 1'b0;
    check_sel(uut.sel, exp_sel);
    @(posedge clk);
    instr_valid <= 1'b0;
    for (cyc = 1; cyc <= MAX_WAIT && !done; cyc++) begin
      if (chain && cyc == n_exp + 1) begin
        @(posedge clk);
        instr_valid <= 1'b1;
        instr       <= nxt;
      end
      @(negedge clk);
      check_bit("busy", busy, cyc <= n_exp);
      if (uop_valid === 1'b1) begin
        if (cyc != got + 2) begin
          errors++;
          $display("micro-op %0d came in cycle %0d instead of cycle %0d", got, cyc, got + 2);
        end
        exp.kind   = ref_kind(exp_sel, got);
        exp.sizeop = ins.sizeop;
        exp.opcode = ins.opcode;
        exp.step   = got[`UC_STEP_W-1:0];
        exp.last   = (got == n_exp - 1);
        check_uop(uop, exp);
        got++;
        done = uop.last || got >= n_exp;
      end
    end
    if (!done) begin
      errors++;
      $display("no last micro-op within %0d cycles, %0d of %0d seen", MAX_WAIT, got, n_exp);
    end
  endtask

  task automatic report(input string tag, input int e0);
    tests++;
    $display("%-8s %s", tag, (errors == e0) ? "ok" : "errors");
  endtask

  initial begin
    int     e0;
    int     i;
    instr_t ins;
    logic [15:0] r;
    clk         = 1'b0;
    arst_n      = 1'b0;
    instr_valid = 1'b0;
    instr       = '0;
    lfsr_state  = 16'd31115;
    errors      = 0;
    tests       = 0;

    // Idle outputs through reset and after it
    e0 = errors;
    repeat (3) @(negedge clk);
    @(posedge clk);
    arst_n <= 1'b1;
    repeat (4) begin
      @(negedge clk);
      check_bit("busy", busy, 1'b0);
      check_bit("uop_valid", uop_valid, 1'b0);
    end
    report("reset", e0);

    for (i = 0; i < NUM_VECS; i++) begin
      e0 = errors;
      issue(VECS[i].ins);
      collect(VECS[i].ins, VECS[i].sel, 1'b0, VECS[i].ins);
      report($sformatf("vec %0d", i), e0);
    end

    for (i = 0; i < NUM_RAND; i++) begin
      e0 = errors;
      ins.opcode = rand_bits(16);
      r = rand_bits(3);
      ins.modrm_reg = r[2:0];
      r = rand_bits(1);
      ins.sizeop = r[0];
      issue(ins);
      collect(ins, decode_ref(ins), 1'b0, ins);
      report($sformatf("rand %0d", i), e0);
    end

    // Whole table back to back
    e0 = errors;
    issue(VECS[0].ins);
    for (i = 0; i < NUM_VECS; i++) begin
      collect(VECS[i].ins, VECS[i].sel, i < NUM_VECS - 1, VECS[(i + 1) % NUM_VECS].ins);
    end
    report("chain", e0);

    $display("tests %0d, errors %0d", tests, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== flist.f ====
+incdir+rtl
rtl/ucode_pkg.sv
rtl/opcode_rom_control.sv
rtl/ucode_rom.sv
rtl/ucode_sequencer.sv
rtl/ucode_decode_top.sv
test/ucode_decode_tb.sv

// ==== Makefile ====
# Verilator build and run for the microcode decode slice

VERILATOR ?= verilator
TOP       ?= ucode_decode_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
FAIL_MSG  := Test failed

SOURCES := $(FLIST) $(wildcard rtl/*.sv rtl/*.svh test/*.sv)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, search $(LOG) for failures"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FLIST BUILD_DIR LOG VFLAGS"

$(BUILD_DIR)/V$(TOP): $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

test: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "simulation reported failure, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
